/* hdl/byte_bus_pkg.sv */
// ----------------------------------------------------------------------
// Shared definitions for the byte-wide bus processor
// Bus and pin widths, frame length, bus request struct,
// opcode and processor state enums
// ----------------------------------------------------------------------
`default_nettype none

package byte_bus_pkg;

  localparam int BUS_WIDTH = 32;  // Address and data word width
  localparam int PIN_WIDTH = 8;   // Width of the byte pins
  localparam int BUS_BYTES = BUS_WIDTH / PIN_WIDTH;
  localparam int FRAME_LEN = 10;  // Clock cycles per processor step

  typedef logic [3:0] phase_t;  // Frame phase, 0 to FRAME_LEN-1

  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [BUS_WIDTH-1:0] addr;   // Word address
    logic [BUS_WIDTH-1:0] wdata;
  } bus_req_t;

  // Opcode in instruction bits 31:28, codes 7 to 15 act as halt
  typedef enum logic [3:0] {
    OP_HALT  = 4'h0,
    OP_LOAD  = 4'h1,
    OP_ADD   = 4'h2,
    OP_SUB   = 4'h3,
    OP_STORE = 4'h4,
    OP_JUMP  = 4'h5,
    OP_JZ    = 4'h6
  } cpu_op_e;

  typedef enum logic [1:0] {
    ST_FETCH   = 2'd0,
    ST_OPERAND = 2'd1,
    ST_WRITE   = 2'd2,
    ST_HALTED  = 2'd3
  } cpu_state_e;

endpackage

`default_nettype wire

/* hdl/bus_phase_counter.sv */
// ----------------------------------------------------------------------
// Frame phase counter
// Counts 1..FRAME_LEN-1 then 0 and pulses the processor step at phase 0
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bus_phase_counter (
  input  logic                 clk,
  input  logic                 rst_n,
  output byte_bus_pkg::phase_t phase,
  output logic                 cpu_step
);

  import byte_bus_pkg::*;

  localparam phase_t START_PHASE = phase_t'(1);             // First frame skips the step
  localparam phase_t LAST_PHASE  = phase_t'(FRAME_LEN - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= START_PHASE;
    end else if (phase == LAST_PHASE) begin
      phase <= '0;                          // Wrap to the step phase
    end else begin
      phase <= phase + phase_t'(1);
    end
  end

  // One cycle per frame
  assign cpu_step = (phase == '0);

endmodule

`default_nettype wire

/* hdl/accum_cpu.sv */
// ----------------------------------------------------------------------
// Accumulator processor
// Fetch, operand read and write steps, one bus request per step
// Instruction word holds opcode in 31:28 and operand in 27:0
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module accum_cpu #(
  parameter logic [byte_bus_pkg::BUS_WIDTH-1:0] RESET_VECTOR = '0
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 cpu_step,
  input  logic [byte_bus_pkg::BUS_WIDTH-1:0]   rdata,
  output byte_bus_pkg::bus_req_t               req,
  output logic                                 halted
);

  import byte_bus_pkg::*;

  localparam int OPND_W = 28;  // Operand field width

  cpu_state_e           state;
  cpu_op_e              op_q;      // Opcode waiting for its operand
  cpu_op_e              dec_op;
  logic [BUS_WIDTH-1:0] pc;
  logic [BUS_WIDTH-1:0] acc;
  logic [BUS_WIDTH-1:0] opr_addr;  // Operand address of the pending access
  logic [BUS_WIDTH-1:0] dec_opnd;
  logic [BUS_WIDTH-1:0] pc_inc;

  always_comb begin
    dec_op   = cpu_op_e'(rdata[BUS_WIDTH-1:OPND_W]);
    dec_opnd = {{(BUS_WIDTH - OPND_W){1'b0}}, rdata[OPND_W-1:0]};
    pc_inc   = pc + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_FETCH;      // First frame fetches from the reset vector
      pc    <= RESET_VECTOR;
      acc   <= '0;
      op_q  <= OP_HALT;
    end else if (cpu_step) begin
      case (state)
        ST_FETCH: begin
          op_q <= dec_op;
          case (dec_op)
            OP_LOAD, OP_ADD, OP_SUB: begin
              state <= ST_OPERAND;
            end
            OP_STORE: begin
              state <= ST_WRITE;
            end
            OP_JUMP: begin
              pc <= dec_opnd;
            end
            OP_JZ: begin
              pc <= (acc == '0) ? dec_opnd : pc_inc;
            end
            default: begin
              state <= ST_HALTED;   // HALT and unknown codes
            end
          endcase
        end
        ST_OPERAND: begin
          case (op_q)
            OP_LOAD: acc <= rdata;
            OP_ADD:  acc <= acc + rdata;  // Wraps modulo 2^32
            OP_SUB:  acc <= acc - rdata;
            default: acc <= acc;
          endcase
          pc    <= pc_inc;
          state <= ST_FETCH;
        end
        ST_WRITE: begin
          pc    <= pc_inc;
          state <= ST_FETCH;
        end
        default: begin
          state <= ST_HALTED;       // Stays until reset
        end
      endcase
    end
  end

  // Operand address for the following read or write step
  always_ff @(posedge clk) begin
    if (cpu_step && state == ST_FETCH) begin
      opr_addr <= dec_opnd;
    end
  end

  // Request is decoded from registered state, so it holds between steps
  always_comb begin
    req       = '0;
    req.valid = (state != ST_HALTED);
    req.write = (state == ST_WRITE);
    if (state == ST_OPERAND || state == ST_WRITE) begin
      req.addr = opr_addr;
    end else begin
      req.addr = pc;
    end
    if (state == ST_WRITE) begin
      req.wdata = acc;
    end
  end

  assign halted = (state == ST_HALTED);

endmodule

`default_nettype wire

/* hdl/byte_bus_bridge.sv */
// ----------------------------------------------------------------------
// Byte bus bridge
// Serializes request address and write data onto byte pins,
// collects read data bytes into a word for the processor
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module byte_bus_bridge (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  byte_bus_pkg::phase_t                 phase,
  input  byte_bus_pkg::bus_req_t               req,
  output logic [byte_bus_pkg::BUS_WIDTH-1:0]   rdata,
  output logic [byte_bus_pkg::PIN_WIDTH-1:0]   addr_byte,
  output logic [byte_bus_pkg::PIN_WIDTH-1:0]   data_out,
  output logic [byte_bus_pkg::PIN_WIDTH-1:0]   data_oe,
  input  logic [byte_bus_pkg::PIN_WIDTH-1:0]   data_in,
  output logic                                 bus_sync
);

  import byte_bus_pkg::*;

  localparam int SEL_W = $clog2(BUS_BYTES);

  // Pins are registered, so selection runs one phase ahead of the pins
  localparam phase_t DRIVE_FIRST = phase_t'(1);
  localparam phase_t DRIVE_LAST  = phase_t'(BUS_BYTES);
  localparam phase_t CAPT_FIRST  = phase_t'(FRAME_LEN - BUS_BYTES);
  localparam phase_t CAPT_LAST   = phase_t'(FRAME_LEN - 1);

  logic                 drive_win;   // Next phase carries a request byte
  logic                 capt_win;    // Read byte present on data_in
  logic                 wr_drive;
  phase_t               sel_phase;
  logic [SEL_W-1:0]     byte_sel;
  logic [PIN_WIDTH-1:0] addr_next;
  logic [PIN_WIDTH-1:0] wdata_next;

  always_comb begin
    drive_win = req.valid && (phase >= DRIVE_FIRST) && (phase <= DRIVE_LAST);
    capt_win  = req.valid && !req.write && (phase >= CAPT_FIRST) && (phase <= CAPT_LAST);
    wr_drive  = drive_win && req.write;
    sel_phase = phase - DRIVE_FIRST;
    byte_sel  = sel_phase[SEL_W-1:0];   // Least significant byte first
    addr_next  = '0;
    wdata_next = '0;
    if (drive_win) begin
      addr_next = req.addr[byte_sel*PIN_WIDTH +: PIN_WIDTH];
    end
    if (wr_drive) begin
      wdata_next = req.wdata[byte_sel*PIN_WIDTH +: PIN_WIDTH];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_byte <= '0;
      data_out  <= '0;
      data_oe   <= '0;
      bus_sync  <= 1'b0;
    end else begin
      addr_byte <= addr_next;
      data_out  <= wdata_next;
      data_oe   <= {PIN_WIDTH{wr_drive}};      // Enable follows the write flag
      bus_sync  <= req.valid && (phase == DRIVE_FIRST);  // Marks address byte 0
    end
  end

  // Bytes enter at the top, so byte 0 ends up in the low lane
  always_ff @(posedge clk) begin
    if (capt_win) begin
      rdata <= {data_in, rdata[BUS_WIDTH-1:PIN_WIDTH]};
    end
  end

endmodule

`default_nettype wire

/* hdl/byte_bus_top.sv */
// ----------------------------------------------------------------------
// Top level of the byte bus processor
// Phase counter, accumulator processor and byte bus bridge
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module byte_bus_top #(
  parameter logic [byte_bus_pkg::BUS_WIDTH-1:0] RESET_VECTOR = '0
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  output logic [byte_bus_pkg::PIN_WIDTH-1:0]   addr_byte,
  output logic [byte_bus_pkg::PIN_WIDTH-1:0]   data_out,
  output logic [byte_bus_pkg::PIN_WIDTH-1:0]   data_oe,
  input  logic [byte_bus_pkg::PIN_WIDTH-1:0]   data_in,
  output logic                                 bus_sync,
  output logic                                 halted
);

  import byte_bus_pkg::*;

  phase_t               phase;
  logic                 cpu_step;
  bus_req_t             req;
  logic [BUS_WIDTH-1:0] rdata;    // Assembled read word

  bus_phase_counter u_phase (
    .clk      (clk),
    .rst_n    (rst_n),
    .phase    (phase),
    .cpu_step (cpu_step)
  );

  accum_cpu #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_cpu (
    .clk      (clk),
    .rst_n    (rst_n),
    .cpu_step (cpu_step),
    .rdata    (rdata),
    .req      (req),
    .halted   (halted)
  );

  byte_bus_bridge u_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .phase     (phase),
    .req       (req),
    .rdata     (rdata),
    .addr_byte (addr_byte),
    .data_out  (data_out),
    .data_oe   (data_oe),
    .data_in   (data_in),
    .bus_sync  (bus_sync)
  );

endmodule

`default_nettype wire

/* testbench/byte_bus_assertions.sv */
// ----------------------------------------------------------------------
// Concurrent assertions on the byte bus pins
// Sync spacing, output enable shape and window, halt behavior
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module byte_bus_assertions (
  input wire logic                               clk,
  input wire logic                               rst_n,
  input wire logic                               bus_sync,
  input wire logic [byte_bus_pkg::PIN_WIDTH-1:0] data_oe,
  input wire logic                               halted
);

  import byte_bus_pkg::*;

  int   since_sync;  // Cycles since the last sync pulse
  logic seen_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      since_sync <= 0;
      seen_sync  <= 1'b0;
    end else if (bus_sync) begin
      since_sync <= 1;
      seen_sync  <= 1'b1;
    end else if (since_sync < 1000) begin
      since_sync <= since_sync + 1;
    end
  end

  sync_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_sync && seen_sync) |-> (since_sync == FRAME_LEN))
    else $error("bus_sync pulses not one frame apart");

  // Enable is all ones only in the sync cycle and the three after it
  oe_shape: assert property (@(posedge clk) disable iff (!rst_n)
    (data_oe == '0) ||
    ((data_oe == '1) &&
     (bus_sync || (seen_sync && since_sync >= 1 && since_sync <= 3))))
    else $error("data_oe not a full enable inside the transfer phases");

  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else $error("halted dropped without reset");

  halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> (!bus_sync && data_oe == '0))
    else $error("bus active while halted");

endmodule

bind byte_bus_top byte_bus_assertions u_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .bus_sync (bus_sync),
  .data_oe  (data_oe),
  .halted   (halted)
);

`default_nettype wire

/* testbench/bus_monitor.sv */
// ----------------------------------------------------------------------
// Bus checker
// Rebuilds each frame from the pins and compares it with the expected list
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bus_monitor #(
  parameter int MAX_EXP = 64
) (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic [7:0]  addr_byte,
  input wire logic [7:0]  data_out,
  input wire logic [7:0]  data_oe,
  input wire logic [7:0]  data_in,
  input wire logic        bus_sync,
  input wire logic        halted,
  input wire logic        last_run,   // Halt is expected to end the list
  input var  int          exp_count,
  input wire logic        exp_write [0:MAX_EXP-1],
  input wire logic [31:0] exp_addr  [0:MAX_EXP-1],
  input wire logic [31:0] exp_data  [0:MAX_EXP-1],
  output int              mismatch_count,
  output int              other_count
);

  int          ph;      // Phase of the current cycle, 15 when idle
  int          idx;
  logic        halted_q;
  logic        f_write;
  logic [31:0] f_addr;
  logic [31:0] f_wdata;
  logic [31:0] f_rdata;

  initial begin
    mismatch_count = 0;
    other_count    = 0;
    idx            = 0;
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
    if (got !== expv) begin
      $display("mismatch frame %0d %s: got %h expected %h", idx, name, got, expv);
      mismatch_count++;
    end
  endtask

  task automatic compare_frame();
    if (idx >= exp_count) begin
      $display("Frame at address %h arrived after the expected list ran out", f_addr);
      other_count++;
    end else begin
      check_field("write", {31'd0, f_write}, {31'd0, exp_write[idx]});
      check_field("addr", f_addr, exp_addr[idx]);
      check_field("data", f_write ? f_wdata : f_rdata, exp_data[idx]);
      idx++;
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      ph       = 15;
      halted_q = 1'b0;
    end else begin
      if (bus_sync) ph = 2;
      else if (ph < 15) ph = ph + 1;
      if (ph >= 2 && ph <= 5) begin
        f_addr[(ph-2)*8 +: 8]  = addr_byte;
        f_wdata[(ph-2)*8 +: 8] = data_out;
        if (ph == 2) f_write = (data_oe != 8'h00);
        else check_field("data_oe", {24'd0, data_oe}, {24'd0, {8{f_write}}});
      end else if (addr_byte != 8'h00 || data_out != 8'h00) begin
        $display("Address or data pins active outside the transfer phases");
        other_count++;
      end
      if (ph >= 6 && ph <= 9) f_rdata[(ph-6)*8 +: 8] = data_in;
      if (ph == 9) compare_frame();
      if (halted && (bus_sync || data_oe != 8'h00 || addr_byte != 8'h00)) begin
        $display("Bus activity seen while the processor is halted");
        other_count++;
      end
      if (halted && !halted_q && last_run && idx < exp_count) begin
        $display("Processor halted with %0d expected frames left", exp_count - idx);
        other_count++;
      end
      halted_q = halted;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_byte_bus.sv */
// ----------------------------------------------------------------------
// Testbench top for the byte bus processor
// Clock, reset, stimulus loading, memory model, noise LFSR, final report
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_byte_bus;

  import byte_bus_pkg::*;

  localparam logic [31:0] RESET_VECTOR = 32'h0000_0010;
  localparam int          MAX_EXP      = 64;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic [7:0]  addr_byte;
  logic [7:0]  data_out;
  logic [7:0]  data_oe;
  logic [7:0]  data_in;
  logic        bus_sync;
  logic        halted;
  logic        last_run;
  logic [31:0] mem [0:255];
  logic        exp_write [0:MAX_EXP-1];
  logic [31:0] exp_addr  [0:MAX_EXP-1];
  logic [31:0] exp_data  [0:MAX_EXP-1];
  int          exp_count;
  int          mismatch_count;
  int          other_count;
  int          cycle_count;
  int          cycle_limit;
  int          mph;          // Memory model phase, 15 when idle
  logic        m_write;
  logic [31:0] m_addr;
  logic [31:0] m_wdata;
  logic [31:0] lfsr;
  logic        stim_ok;
  logic        timed_out;

  byte_bus_top #(.RESET_VECTOR(RESET_VECTOR)) dut0 (
    .clk(clk), .rst_n(rst_n), .addr_byte(addr_byte), .data_out(data_out),
    .data_oe(data_oe), .data_in(data_in), .bus_sync(bus_sync), .halted(halted)
  );

  bus_monitor #(.MAX_EXP(MAX_EXP)) u_monitor (
    .clk(clk), .rst_n(rst_n), .addr_byte(addr_byte), .data_out(data_out),
    .data_oe(data_oe), .data_in(data_in), .bus_sync(bus_sync), .halted(halted),
    .last_run(last_run), .exp_count(exp_count), .exp_write(exp_write),
    .exp_addr(exp_addr), .exp_data(exp_data),
    .mismatch_count(mismatch_count), .other_count(other_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // One Galois step per noise bit
  function automatic logic [7:0] noise_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return b;
  endfunction

  task automatic load_stim(output logic opened);
    int          fd;
    string       line;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] d;
    opened = 1'b0;
    for (int i = 0; i < 256; i++) mem[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0]};
    exp_count = 0;
    fd = $fopen("testbench/byte_bus_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
    end else begin
      opened = 1'b1;
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          if ($sscanf(line, "M %h %h", a, d) == 2) begin
            mem[a[7:0]] = d;
          end else if ($sscanf(line, "E %h %h %h", w, a, d) == 3 && exp_count < MAX_EXP) begin
            exp_write[exp_count] = w[0];
            exp_addr[exp_count]  = a;
            exp_data[exp_count]  = d;
            exp_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Memory model follows the frame from bus_sync
  always @(negedge clk) begin
    if (!rst_n) begin
      mph = 15;
    end else begin
      if (bus_sync) mph = 2;
      else if (mph < 15) mph = mph + 1;
      if (mph >= 2 && mph <= 5) begin
        m_addr[(mph-2)*8 +: 8]  = addr_byte;
        m_wdata[(mph-2)*8 +: 8] = data_out;
        if (mph == 2) m_write = (data_oe != 8'h00);
      end
      if (mph == 5 && m_write) mem[m_addr[7:0]] = m_wdata;
    end
  end

  always @(posedge clk) begin
    #1;
    if (mph >= 5 && mph <= 8 && !m_write) data_in = mem[m_addr[7:0]][(mph-5)*8 +: 8];
    else data_in = noise_byte();   // Read byte k goes out in phase 6+k
  end

  task automatic run_program(input logic is_last, output logic timed_out);
    timed_out = 1'b0;
    @(posedge clk);
    #1 rst_n = 1'b0;
    last_run = is_last;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    while (!halted && cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    if (!halted) begin
      $display("Timeout after %0d cycles without the processor halting", cycle_count);
      timed_out = 1'b1;
    end else begin
      repeat (2 * FRAME_LEN) @(posedge clk);   // Bus must stay quiet
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    data_in     = 8'h00;
    last_run    = 1'b0;
    lfsr        = 32'hd851;
    mph         = 15;
    m_write     = 1'b0;
    cycle_count = 0;
    timed_out   = 1'b0;
    load_stim(stim_ok);
    if (!stim_ok) begin
      $display("TESTBENCH FAILED");
    end else begin
      cycle_limit = (exp_count + 4) * FRAME_LEN;
      run_program(1'b0, timed_out);     // Ends on HALT after setting the flag word
      if (!timed_out) begin
        run_program(1'b1, timed_out);   // Ends on an unknown opcode
      end
      $display("Errors: %0d mismatch, %0d other", mismatch_count, other_count);
      if (!timed_out && mismatch_count == 0 && other_count == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/byte_bus_pkg.sv
hdl/bus_phase_counter.sv
hdl/accum_cpu.sv
hdl/byte_bus_bridge.sv
hdl/byte_bus_top.sv
testbench/byte_bus_assertions.sv
testbench/bus_monitor.sv
testbench/tb_byte_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the byte bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_byte_bus -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* testbench/byte_bus_stim.txt */
# M <word addr> <data>            memory image, hex
# E <write> <word addr> <data>    expected bus frames in order, hex
M 10 10000060
M 11 60000020
M 12 50000030
M 20 10000040
M 21 20000041
M 22 30000042
M 23 40000060
M 24 10000060
M 25 60000030
M 26 00000000
M 30 F0000000
M 40 FFFFFFF0
M 41 00000020
M 42 00000003
M 60 00000000
# First run, flag word at 60 is zero
E 0 10 10000060
E 0 60 00000000
E 0 11 60000020
E 0 20 10000040
E 0 40 FFFFFFF0
E 0 21 20000041
E 0 41 00000020
E 0 22 30000042
E 0 42 00000003
E 0 23 40000060
E 1 60 0000000D
E 0 24 10000060
E 0 60 0000000D
E 0 25 60000030
E 0 26 00000000
# Second run after reset, flag is set so the jump reaches 30
E 0 10 10000060
E 0 60 0000000D
E 0 11 60000020
E 0 12 50000030
E 0 30 F0000000
